// File: sim.f
hw/bench_pkg.sv
hw/run_ctrl.sv
hw/data_bank.sv
hw/lane_kernel.sv
hw/xor_fold.sv
hw/bench_top.sv
tests/tb_bench_top.sv

// File: Makefile
TOP := tb_bench_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_bin

run: build
	./obj_dir/sim_bin | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: tests/tb_bench_top.sv
`timescale 1ns/1ps

module tb_bench_top;

    localparam int NUM_RUNS   = 10;
    localparam int WD_CYCLES  = NUM_RUNS * 64 + 200;
    localparam int IDLE_LIMIT = bench_pkg::DATA_SIZE + 8;
    localparam int DONE_LIMIT = bench_pkg::DATA_SIZE + 4;
    // last result leaves the fold 5 cycles after ap_done
    localparam int PIPE_DRAIN = 8;

    logic             ap_clk;
    logic             rst_n;
    logic             ap_start;
    bench_pkg::word_t alpha;
    bench_pkg::word_t beta;
    logic [3:0]       lane_mask;
    logic             ap_done;
    logic             ap_idle;
    bench_pkg::nib_t  data_out;
    logic             data_valid;

    logic [31:0]      lfsr;
    bench_pkg::nib_t  exp_q [$];
    int               runs_taken;
    int               done_seen;

    bench_top dut_i (
        .ap_clk(ap_clk), .rst_n(rst_n), .ap_start(ap_start), .alpha(alpha), .beta(beta),
        .lane_mask(lane_mask), .ap_done(ap_done), .ap_idle(ap_idle), .data_out(data_out),
        .data_valid(data_valid)
    );

    always #5 ap_clk = ~ap_clk;

    // ######################################################################
    // helpers
    // ######################################################################
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        // taps 32 22 2 1
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] rom_value(input int bank, input int ds, input int idx);
        logic [31:0] w_idx;
        logic [31:0] w_ds;
        logic [31:0] w_bank;
        w_idx  = 32'(idx) * bench_pkg::ROM_K_IDX;
        w_ds   = 32'(ds) * bench_pkg::ROM_K_DS;
        w_bank = 32'(bank) << 24;
        return w_idx ^ w_ds ^ w_bank;
    endfunction

    // enabled lanes folded into one byte whose nibbles are then xored
    function automatic bench_pkg::nib_t expect_nib(input int run, input int idx,
                                                   input logic [3:0] mask,
                                                   input logic [31:0] al,
                                                   input logic [31:0] be);
        int          ds;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [7:0]  acc;
        ds  = (run / bench_pkg::UPDATE_INV) % bench_pkg::DATASET_NUM;
        acc = 8'h00;
        for (int l = 0; l < bench_pkg::LANES; l++)
        begin
            a = rom_value(l, ds, idx);
            b = rom_value(l + bench_pkg::LANES, ds, idx);
            c = al * a + be * b;
            if (mask[l])
                acc = acc ^ c[7:0] ^ c[15:8] ^ c[23:16] ^ c[31:24];
        end
        return acc[7:4] ^ acc[3:0];
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (!ap_idle)
        begin
            assert (!ap_done && !data_valid)
                else fail_now("output activity while waiting for ap_idle");
            n++;
            assert (n <= IDLE_LIMIT)
                else fail_now("ap_idle did not rise after the refill");
            @(posedge ap_clk);
            #1;
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!ap_done)
        begin
            n++;
            assert (n <= DONE_LIMIT)
                else fail_now("ap_done did not arrive at the end of the run");
            @(posedge ap_clk);
            #1;
        end
    endtask

    // start pulse that the DUT must ignore
    task automatic poke_start();
        assert (!ap_idle)
            else fail_now("ap_idle was high where the DUT should be busy");
        ap_start = 1'b1;
        @(posedge ap_clk);
        #1;
        ap_start = 1'b0;
    endtask

    task automatic start_run(input logic [3:0] mask);
        logic [31:0] r;
        draw_bits(32, r);
        alpha = r;
        draw_bits(32, r);
        beta      = r;
        lane_mask = mask;
        if (mask != 4'h0)
        begin
            for (int i = 0; i < bench_pkg::DATA_SIZE; i++)
                exp_q.push_back(expect_nib(runs_taken, i, mask, alpha, beta));
        end
        ap_start = 1'b1;
        @(posedge ap_clk);
        #1;
        ap_start = 1'b0;
        runs_taken++;
    endtask

    // ######################################################################
    // comparison and monitors
    // ######################################################################
    always @(negedge ap_clk)
    begin : compare
        bench_pkg::nib_t exp_v;
        if (rst_n && data_valid)
        begin
            assert (exp_q.size() > 0)
                else fail_now("data_valid rose with no result expected");
            exp_v = exp_q.pop_front();
            assert (data_out == exp_v)
                else fail_now($sformatf("** Error data_out: expected 0x%h, got 0x%h",
                                        exp_v, data_out));
        end
    end

    always @(negedge ap_clk)
    begin
        if (rst_n && ap_done)
            done_seen++;
    end

    initial
    begin
        repeat (WD_CYCLES) @(posedge ap_clk);
        fail_now("watchdog expired before the test finished");
    end

    // ######################################################################
    // stimulus
    // ######################################################################
    initial
    begin
        logic [31:0] r;
        logic [3:0]  mask;
        ap_clk     = 1'b0;
        rst_n      = 1'b0;
        ap_start   = 1'b0;
        alpha      = '0;
        beta       = '0;
        lane_mask  = '0;
        lfsr       = 32'h77af_da1e;
        runs_taken = 0;
        done_seen  = 0;
        repeat (16) @(posedge ap_clk);
        #1;
        rst_n = 1'b1;

        for (int run = 0; run < NUM_RUNS; run++)
        begin
            wait_idle();
            // full, full, empty, single lanes, then random masks
            case (run)
                0, 1:    mask = 4'hf;
                2:       mask = 4'h0;
                3:       mask = 4'h1;
                4:       mask = 4'h8;
                default:
                begin
                    draw_bits(4, r);
                    mask = r[3:0];
                end
            endcase
            start_run(mask);
            if (run % 2 == 1)
            begin
                repeat (4) @(posedge ap_clk);
                #1;
                poke_start();
            end
            wait_done();
            // controller now busy with the refill after this run
            if (runs_taken % bench_pkg::UPDATE_INV == 0)
                poke_start();
            repeat (PIPE_DRAIN) @(posedge ap_clk);
            #1;
            assert (done_seen == runs_taken)
                else fail_now($sformatf("** Error ap_done count: expected 0x%h, got 0x%h",
                                        runs_taken, done_seen));
        end

        if (exp_q.size() != 0)
            fail_now($sformatf("%0d expected results never arrived", exp_q.size()));
        else
        begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: hw/bench_top.sv
`timescale 1ns/1ps

module bench_top (
    input  logic              ap_clk,
    input  logic              rst_n,
    input  logic              ap_start,
    input  bench_pkg::word_t  alpha,
    input  bench_pkg::word_t  beta,
    input  logic [3:0]        lane_mask,
    output logic              ap_done,
    output logic              ap_idle,
    output bench_pkg::nib_t   data_out,
    output logic              data_valid
);

    logic                                          rd_en;
    bench_pkg::idx_t                               rd_idx;
    logic                                          swap;
    logic                                          fill_req;
    bench_pkg::ds_t                                fill_ds;
    logic                                          fill_busy;
    bench_pkg::word_t                              a_data [bench_pkg::LANES];
    bench_pkg::word_t                              b_data [bench_pkg::LANES];
    logic [bench_pkg::LANES-1:0]                   a_valid;
    bench_pkg::word_t [bench_pkg::LANES-1:0]       lane_res;
    logic [bench_pkg::LANES-1:0]                   lane_wr;

    run_ctrl ctrl_i (
        .ap_clk(ap_clk), .rst_n(rst_n), .ap_start(ap_start), .fill_busy(fill_busy),
        .ap_done(ap_done), .ap_idle(ap_idle), .rd_en(rd_en), .rd_idx(rd_idx),
        .swap(swap), .fill_req(fill_req), .fill_ds(fill_ds)
    );

    // ####################################################################
    // banks and lanes, A banks 0..3 and B banks 4..7
    // ####################################################################
    for (genvar i = 0; i < bench_pkg::LANES; i++)
    begin : g_lane
        // all banks fill in lockstep, bank 0 reports for them
        if (i == 0)
        begin : g_a0
            data_bank #(.BANK_ID(i)) a_bank_i (
                .ap_clk(ap_clk), .rst_n(rst_n), .rd_en(rd_en), .rd_idx(rd_idx),
                .swap(swap), .fill_req(fill_req), .fill_ds(fill_ds),
                .rd_data(a_data[i]), .rd_valid(a_valid[i]), .fill_busy(fill_busy)
            );
        end
        else
        begin : g_an
            data_bank #(.BANK_ID(i)) a_bank_i (
                .ap_clk(ap_clk), .rst_n(rst_n), .rd_en(rd_en), .rd_idx(rd_idx),
                .swap(swap), .fill_req(fill_req), .fill_ds(fill_ds),
                .rd_data(a_data[i]), .rd_valid(a_valid[i]), .fill_busy()
            );
        end

        data_bank #(.BANK_ID(i + bench_pkg::LANES)) b_bank_i (
            .ap_clk(ap_clk), .rst_n(rst_n), .rd_en(rd_en), .rd_idx(rd_idx),
            .swap(swap), .fill_req(fill_req), .fill_ds(fill_ds),
            .rd_data(b_data[i]), .rd_valid(), .fill_busy()
        );

        lane_kernel lane_i (
            .ap_clk(ap_clk), .rst_n(rst_n), .a(a_data[i]), .b(b_data[i]),
            .in_valid(a_valid[i]), .alpha(alpha), .beta(beta), .lane_en(lane_mask[i]),
            .res(lane_res[i]), .res_wr(lane_wr[i])
        );
    end

    xor_fold fold_i (
        .ap_clk(ap_clk), .rst_n(rst_n), .res(lane_res), .res_wr(lane_wr),
        .data_out(data_out), .data_valid(data_valid)
    );

endmodule

// File: hw/xor_fold.sv
`timescale 1ns/1ps

module xor_fold (
    input  logic                   ap_clk,
    input  logic                   rst_n,
    input  bench_pkg::word_t [3:0] res,
    input  logic [3:0]             res_wr,
    output bench_pkg::nib_t        data_out,
    output logic                   data_valid
);

    // select/xor of a pair: lone valid passes, both valid xor, none gives zero
    function automatic bench_pkg::byte_t pick(input bench_pkg::byte_t x0,
                                              input bench_pkg::byte_t x1,
                                              input logic v0,
                                              input logic v1);
        bench_pkg::byte_t r;
        case ({v1, v0})
            2'b01:   r = x0;
            2'b10:   r = x1;
            2'b11:   r = x0 ^ x1;
            default: r = '0;
        endcase
        return r;
    endfunction

    bench_pkg::byte_t s1 [4];
    logic [3:0]       v1;
    bench_pkg::byte_t s2 [2];
    logic [1:0]       v2;
    bench_pkg::byte_t s3;
    logic             v3;

    // ####################################################################
    // valid pipeline
    // ####################################################################
    always_ff @(posedge ap_clk)
    begin
        if (!rst_n)
        begin
            v1         <= '0;
            v2         <= '0;
            v3         <= 1'b0;
            data_valid <= 1'b0;
        end
        else
        begin
            v1         <= res_wr;
            v2         <= {v1[3] | v1[2], v1[1] | v1[0]};
            v3         <= v2[1] | v2[0];
            data_valid <= v3;
        end
    end

    // ####################################################################
    // data pipeline
    // ####################################################################
    always_ff @(posedge ap_clk)
    begin
        // stage 1: bytes of each lane
        for (int i = 0; i < 4; i++)
            s1[i] <= res[i][7:0] ^ res[i][15:8] ^ res[i][23:16] ^ res[i][31:24];
        // stages 2 and 3: reduce by valid
        s2[0]    <= pick(s1[0], s1[1], v1[0], v1[1]);
        s2[1]    <= pick(s1[2], s1[3], v1[2], v1[3]);
        s3       <= pick(s2[0], s2[1], v2[0], v2[1]);
        data_out <= s3[7:4] ^ s3[3:0];
    end

endmodule

// File: hw/lane_kernel.sv
`timescale 1ns/1ps

module lane_kernel (
    input  logic              ap_clk,
    input  logic              rst_n,
    input  bench_pkg::word_t  a,
    input  bench_pkg::word_t  b,
    input  logic              in_valid,
    input  bench_pkg::word_t  alpha,
    input  bench_pkg::word_t  beta,
    input  logic              lane_en,
    output bench_pkg::word_t  res,
    output logic              res_wr
);

    bench_pkg::word_t mac;

    // products wrap mod 2^32
    assign mac = (alpha * a) + (beta * b);

    always_ff @(posedge ap_clk)
    begin
        if (!rst_n)
            res_wr <= 1'b0;
        else
            res_wr <= in_valid & lane_en;
    end

    always_ff @(posedge ap_clk)
    begin
        if (in_valid)
            res <= mac;
    end

endmodule

// File: hw/data_bank.sv
`timescale 1ns/1ps

module data_bank #(
    parameter int BANK_ID = 0
) (
    input  logic              ap_clk,
    input  logic              rst_n,
    input  logic              rd_en,
    input  bench_pkg::idx_t   rd_idx,
    input  logic              swap,
    input  logic              fill_req,
    input  bench_pkg::ds_t    fill_ds,
    output bench_pkg::word_t  rd_data,
    output logic              rd_valid,
    output logic              fill_busy
);

    localparam bench_pkg::idx_t  LAST_IDX = bench_pkg::idx_t'(bench_pkg::DATA_SIZE - 1);
    localparam bench_pkg::byte_t BANK_NUM = bench_pkg::byte_t'(BANK_ID);

    // two halves, act selects the one feeding reads
    bench_pkg::word_t mem [2][bench_pkg::DATA_SIZE];

    logic             act;
    logic             fill_pend;
    bench_pkg::idx_t  fill_idx;
    bench_pkg::ds_t   fill_ds_q;
    logic             rd_half;

    // a read issued with the swap pulse already sees the new half
    assign rd_half = (swap && fill_pend) ? ~act : act;

    // ####################################################################
    // control
    // ####################################################################
    always_ff @(posedge ap_clk)
    begin
        if (!rst_n)
        begin
            act       <= 1'b0;
            fill_pend <= 1'b0;
            fill_busy <= 1'b0;
            fill_idx  <= '0;
            rd_valid  <= 1'b0;
        end
        else
        begin
            rd_valid <= rd_en;
            if (swap && fill_pend)
            begin
                act       <= ~act;
                fill_pend <= 1'b0;
            end
            if (fill_req)
            begin
                fill_busy <= 1'b1;
                fill_idx  <= '0;
            end
            else if (fill_busy)
            begin
                fill_idx <= fill_idx + 1'b1;
                if (fill_idx == LAST_IDX)
                begin
                    fill_busy <= 1'b0;
                    fill_pend <= 1'b1;
                end
            end
        end
    end

    // ####################################################################
    // storage
    // ####################################################################
    always_ff @(posedge ap_clk)
    begin
        if (fill_req)
            fill_ds_q <= fill_ds;
        // refill walks the shadow half only
        if (fill_busy)
            mem[~act][fill_idx] <= bench_pkg::rom_word(BANK_NUM, fill_ds_q, fill_idx);
        if (rd_en)
            rd_data <= mem[rd_half][rd_idx];
    end

endmodule

// File: hw/run_ctrl.sv
`timescale 1ns/1ps

module run_ctrl (
    input  logic              ap_clk,
    input  logic              rst_n,
    input  logic              ap_start,
    input  logic              fill_busy,
    output logic              ap_done,
    output logic              ap_idle,
    output logic              rd_en,
    output bench_pkg::idx_t   rd_idx,
    output logic              swap,
    output logic              fill_req,
    output bench_pkg::ds_t    fill_ds
);

    typedef enum logic [1:0] {
        FILL_WAIT,
        IDLE,
        RUN
    } state_t;

    localparam bench_pkg::idx_t LAST_IDX = bench_pkg::idx_t'(bench_pkg::DATA_SIZE - 1);

    state_t     state;
    logic [7:0] run_cnt;
    logic [7:0] run_cnt_nxt;

    assign run_cnt_nxt = run_cnt + 8'd1;
    assign ap_idle     = (state == IDLE);

    always_ff @(posedge ap_clk)
    begin
        if (!rst_n)
        begin
            state    <= FILL_WAIT;
            run_cnt  <= 8'd0;
            rd_en    <= 1'b0;
            rd_idx   <= '0;
            swap     <= 1'b0;
            ap_done  <= 1'b0;
            // first refill loads dataset 0 right after reset
            fill_req <= 1'b1;
            fill_ds  <= '0;
        end
        else
        begin
            swap     <= 1'b0;
            ap_done  <= 1'b0;
            fill_req <= 1'b0;
            case (state)
                FILL_WAIT:
                begin
                    // busy rises one cycle after the request
                    if (!fill_req && !fill_busy)
                        state <= IDLE;
                end
                IDLE:
                begin
                    if (ap_start)
                    begin
                        state  <= RUN;
                        swap   <= 1'b1;
                        rd_en  <= 1'b1;
                        rd_idx <= '0;
                    end
                end
                RUN:
                begin
                    if (rd_idx == LAST_IDX)
                    begin
                        rd_en   <= 1'b0;
                        ap_done <= 1'b1;
                        run_cnt <= run_cnt_nxt;
                        // refill every UPDATE_INV runs
                        if ((run_cnt_nxt % bench_pkg::UPDATE_INV) == 0)
                        begin
                            fill_req <= 1'b1;
                            fill_ds  <= bench_pkg::ds_t'((run_cnt_nxt / bench_pkg::UPDATE_INV)
                                                         % bench_pkg::DATASET_NUM);
                            state    <= FILL_WAIT;
                        end
                        else
                            state <= IDLE;
                    end
                    else
                        rd_idx <= rd_idx + 1'b1;
                end
                default:
                    state <= FILL_WAIT;
            endcase
        end
    end

endmodule

// File: hw/bench_pkg.sv
package bench_pkg;

    // ####################################################################
    // widths with a meaning
    // ####################################################################
    typedef logic [31:0] word_t;
    typedef logic [3:0]  idx_t;
    typedef logic [1:0]  ds_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  nib_t;

    // ####################################################################
    // sizes
    // ####################################################################
    localparam int LANES       = 4;
    localparam int DATA_SIZE   = 16;
    localparam int DATASET_NUM = 4;
    localparam int UPDATE_INV  = 2;

    // dataset rom rule
    localparam word_t ROM_K_IDX = 32'h9e37_79b9;
    localparam word_t ROM_K_DS  = 32'h0100_0193;

    // one rom word: index and dataset hashes, bank number in the top byte
    function automatic word_t rom_word(input byte_t bank, input ds_t ds, input idx_t idx);
        word_t w_idx;
        word_t w_ds;
        w_idx = word_t'(idx) * ROM_K_IDX;
        w_ds  = word_t'(ds) * ROM_K_DS;
        return w_idx ^ w_ds ^ {bank, 24'h00_0000};
    endfunction

endpackage
